//--- include/alu_settings.svh
/*
  sizing of the vector ALU
  the lane logic assumes ALU_W is ALU_LANES byte lanes of ALU_LANE_W bits
  ALU_DIV_STEPS must equal ALU_W for the divider to produce a full quotient
*/
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// data path width
`define ALU_W 32

// byte lane width and count
`define ALU_LANE_W 8
`define ALU_LANES 4

// one restoring step per quotient bit
`define ALU_DIV_STEPS 32

`endif

//--- hdl/alu_op_pkg.sv
/*
  operator encoding of the ALU and the operator classes
  the encoding is 6 bits wide, unlisted codes give a zero result
*/
package alu_op_pkg;

  typedef enum logic [5:0] {
    ALU_LTS  = 6'b000000, ALU_LTU  = 6'b000001, ALU_LES  = 6'b000100, ALU_LEU  = 6'b000101,
    ALU_GTS  = 6'b001000, ALU_GTU  = 6'b001001, ALU_GES  = 6'b001010, ALU_GEU  = 6'b001011,
    ALU_EQ   = 6'b001100, ALU_NE   = 6'b001101,
    ALU_MIN  = 6'b010000, ALU_MINU = 6'b010001, ALU_MAX  = 6'b010010, ALU_MAXU = 6'b010011,
    ALU_ABS  = 6'b010100, ALU_AND  = 6'b010101,
    ALU_ADD  = 6'b011000, ALU_SUB  = 6'b011001,
    ALU_SRA  = 6'b100100, ALU_SRL  = 6'b100101, ALU_ROR  = 6'b100110, ALU_SLL  = 6'b100111,
    ALU_OR   = 6'b101110, ALU_XOR  = 6'b101111,
    ALU_DIVU = 6'b110000, ALU_DIV  = 6'b110001, ALU_REMU = 6'b110010, ALU_REM  = 6'b110011,
    ALU_CNT  = 6'b110100, ALU_CLB  = 6'b110101, ALU_FF1  = 6'b110110, ALU_FL1  = 6'b110111
  } alu_op_e;

  // ops served by the serial divider
  function automatic logic is_div_op(alu_op_e op);
    return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  endfunction

  // ops that read the top bit of a lane as a sign
  function automatic logic is_signed_op(alu_op_e op);
    return op inside {ALU_LTS, ALU_LES, ALU_GTS, ALU_GES, ALU_MIN, ALU_MAX, ALU_ABS,
                      ALU_SRA, ALU_DIV, ALU_REM, ALU_CLB};
  endfunction

  // ops whose result is the single compare bit
  function automatic logic is_cmp_op(alu_op_e op);
    return op inside {ALU_EQ, ALU_NE, ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU,
                      ALU_GTS, ALU_GTU, ALU_GES, ALU_GEU};
  endfunction

endpackage

//--- hdl/alu_lane_pkg.sv
/*
  vector mode encoding and per-lane flags
  a lane mask carries one flag per byte lane, bit 0 is the lowest byte
*/
`include "alu_settings.svh"

package alu_lane_pkg;

  typedef enum logic [1:0] {
    VEC_MODE32 = 2'b00,
    VEC_MODE16 = 2'b10,
    VEC_MODE8  = 2'b11
  } vec_mode_e;

  typedef logic [`ALU_LANES-1:0] lane_mask_t;

  // marks the bytes where a lane begins, i.e. where carries are cut
  function automatic lane_mask_t lane_starts(vec_mode_e mode);
    lane_mask_t m;
    for (int i = 0; i < `ALU_LANES; i++) begin
      case (mode)
        VEC_MODE8:  m[i] = 1'b1;
        VEC_MODE16: m[i] = (i % 2 == 0);
        default:    m[i] = (i == 0);
      endcase
    end
    return m;
  endfunction

endpackage

//--- hdl/alu_vec_adder.sv
/*
  partitioned adder, one 32 bit lane or two 16 bit or four 8 bit lanes
  a control bit sits below every byte and either passes, kills or
  injects the carry, so no carry crosses a lane boundary
*/
`include "alu_settings.svh"

module alu_vec_adder (
  input  alu_op_pkg::alu_op_e     operator_i,
  input  alu_lane_pkg::vec_mode_e vector_mode_i,
  input  logic [`ALU_W-1:0]       operand_a_i,
  input  logic [`ALU_W-1:0]       operand_b_i,
  output logic [`ALU_W-1:0]       sum_o,
  output logic [`ALU_W-1:0]       neg_a_o
);
  import alu_op_pkg::*;
  import alu_lane_pkg::*;

  localparam int LW = `ALU_LANE_W;
  localparam int XW = `ALU_W + `ALU_LANES;

  lane_mask_t starts;
  logic       sub;

  // expanded 36 bit add, control bits at positions 0, 9, 18 and 27
  function automatic logic [`ALU_W-1:0] part_add(input logic [`ALU_W-1:0] x,
                                                 input logic [`ALU_W-1:0] y,
                                                 input lane_mask_t        start,
                                                 input logic              cin);
    logic [XW-1:0]     xe, ye, se;
    logic [`ALU_W-1:0] res;
    for (int i = 0; i < `ALU_LANES; i++) begin
      // 1/0 passes the carry on, 0/0 kills it, 1/1 injects one
      xe[(LW+1)*i]          = start[i] ? cin : 1'b1;
      ye[(LW+1)*i]          = start[i] & cin;
      xe[(LW+1)*i+1 +: LW]  = x[LW*i +: LW];
      ye[(LW+1)*i+1 +: LW]  = y[LW*i +: LW];
    end
    se = xe + ye;
    for (int i = 0; i < `ALU_LANES; i++) begin
      res[LW*i +: LW] = se[(LW+1)*i+1 +: LW];
    end
    return res;
  endfunction

  assign starts = lane_starts(vector_mode_i);
  assign sub    = (operator_i == ALU_SUB);

  // a - b as a + ~b + 1 per lane
  assign sum_o   = part_add(operand_a_i, sub ? ~operand_b_i : operand_b_i, starts, sub);

  // ~a + 1 per lane, feeds abs
  assign neg_a_o = part_add(~operand_a_i, '0, starts, 1'b1);

endmodule

//--- hdl/alu_vec_shifter.sv
/*
  per-lane shifter built around one right shifter
  left shifts bit-reverse the operand and the lane order of the amounts,
  shift right and reverse back
  amounts come from the low 5/4/3 bits of each lane of operand b
  ROR only rotates in 32 bit mode
*/
`include "alu_settings.svh"

module alu_vec_shifter (
  input  alu_op_pkg::alu_op_e     operator_i,
  input  alu_lane_pkg::vec_mode_e vector_mode_i,
  input  logic [`ALU_W-1:0]       operand_a_i,
  input  logic [`ALU_W-1:0]       operand_b_i,
  output logic [`ALU_W-1:0]       shift_result_o
);
  import alu_op_pkg::*;
  import alu_lane_pkg::*;

  localparam int HW = `ALU_W / 2;
  localparam int LW = `ALU_LANE_W;
  localparam int AW = $clog2(`ALU_W);

  logic                shift_left, shift_arith;
  logic [`ALU_W-1:0]   a_rev, op_a, amt, right_res, left_res;
  logic [2*`ALU_W-1:0] rot_full;

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = is_signed_op(operator_i);

  assign a_rev = {<<{operand_a_i}};
  assign op_a  = shift_left ? a_rev : operand_a_i;

  // the reversed word has its lanes in opposite order
  always_comb begin
    amt = operand_b_i;
    if (shift_left) begin
      case (vector_mode_i)
        VEC_MODE16: amt = {operand_b_i[HW-1:0], operand_b_i[`ALU_W-1:HW]};
        VEC_MODE8:  amt = {<<LW{operand_b_i}};
        default: ;
      endcase
    end
  end

  assign rot_full = {op_a, op_a} >> amt[AW-1:0];

  always_comb begin
    right_res = op_a >> amt[AW-1:0];
    case (vector_mode_i)
      VEC_MODE16: begin
        for (int h = 0; h < 2; h++) begin
          if (shift_arith)
            right_res[HW*h +: HW] = $signed(op_a[HW*h +: HW]) >>> amt[HW*h +: $clog2(HW)];
          else
            right_res[HW*h +: HW] = op_a[HW*h +: HW] >> amt[HW*h +: $clog2(HW)];
        end
      end
      VEC_MODE8: begin
        for (int b = 0; b < `ALU_LANES; b++) begin
          if (shift_arith)
            right_res[LW*b +: LW] = $signed(op_a[LW*b +: LW]) >>> amt[LW*b +: $clog2(LW)];
          else
            right_res[LW*b +: LW] = op_a[LW*b +: LW] >> amt[LW*b +: $clog2(LW)];
        end
      end
      default: begin
        if (shift_arith)
          right_res = $signed(op_a) >>> amt[AW-1:0];
        else if (operator_i == ALU_ROR)
          right_res = rot_full[`ALU_W-1:0];
      end
    endcase
  end

  assign left_res       = {<<{right_res}};
  assign shift_result_o = shift_left ? left_res : right_res;

endmodule

//--- hdl/alu_vec_compare.sv
/*
  lane comparator with min/max/abs selection
  per-byte equal and greater flags are merged into lane flags and then
  copied to every byte of the lane
  only the top byte of a lane is compared signed
  comparison_result_o reflects the top lane
*/
`include "alu_settings.svh"

module alu_vec_compare (
  input  alu_op_pkg::alu_op_e     operator_i,
  input  alu_lane_pkg::vec_mode_e vector_mode_i,
  input  logic [`ALU_W-1:0]       operand_a_i,
  input  logic [`ALU_W-1:0]       operand_b_i,
  input  logic [`ALU_W-1:0]       neg_a_i,
  output logic                    comparison_result_o,
  output logic [`ALU_W-1:0]       minmax_o
);
  import alu_op_pkg::*;
  import alu_lane_pkg::*;

  localparam int LW  = `ALU_LANE_W;
  localparam int TOP = `ALU_LANES - 1;

  lane_mask_t        starts, tops, cmp_signed;
  lane_mask_t        eq_byte, gt_byte, eq_cum, gt_cum, is_eq, is_gt, cmp_res, sel_a;
  logic [`ALU_W-1:0] cmp_b, minmax_b;
  logic              is_abs, do_min;

  assign is_abs     = (operator_i == ALU_ABS);
  assign starts     = lane_starts(vector_mode_i);
  // a byte tops its lane when the next byte starts a new one
  assign tops       = {1'b1, starts[TOP:1]};
  assign cmp_signed = is_signed_op(operator_i) ? tops : '0;
  // abs tests each lane of a against zero
  assign cmp_b      = is_abs ? '0 : operand_b_i;

  always_comb begin
    for (int i = 0; i < `ALU_LANES; i++) begin
      eq_byte[i] = (operand_a_i[LW*i +: LW] == cmp_b[LW*i +: LW]);
      gt_byte[i] = $signed({cmp_signed[i] & operand_a_i[LW*i+LW-1], operand_a_i[LW*i +: LW]}) >
                   $signed({cmp_signed[i] & cmp_b[LW*i+LW-1], cmp_b[LW*i +: LW]});
    end
    // ripple upward inside each lane
    eq_cum[0] = eq_byte[0];
    gt_cum[0] = gt_byte[0];
    for (int i = 1; i < `ALU_LANES; i++) begin
      eq_cum[i] = eq_byte[i] & (starts[i] | eq_cum[i-1]);
      gt_cum[i] = gt_byte[i] | (eq_byte[i] & ~starts[i] & gt_cum[i-1]);
    end
    // copy the top byte result down through its lane
    is_eq[TOP] = eq_cum[TOP];
    is_gt[TOP] = gt_cum[TOP];
    for (int i = TOP - 1; i >= 0; i--) begin
      is_eq[i] = tops[i] ? eq_cum[i] : is_eq[i+1];
      is_gt[i] = tops[i] ? gt_cum[i] : is_gt[i+1];
    end
  end

  always_comb begin
    case (operator_i)
      ALU_NE:           cmp_res = ~is_eq;
      ALU_GTS, ALU_GTU: cmp_res = is_gt;
      ALU_GES, ALU_GEU: cmp_res = is_gt | is_eq;
      ALU_LTS, ALU_LTU: cmp_res = ~(is_gt | is_eq);
      ALU_LES, ALU_LEU: cmp_res = ~is_gt;
      default:          cmp_res = is_eq;
    endcase
  end

  assign comparison_result_o = cmp_res[TOP];

  // min flips the choice of max, abs keeps a when it is above zero
  assign do_min   = operator_i inside {ALU_MIN, ALU_MINU};
  assign sel_a    = is_gt ^ {`ALU_LANES{do_min}};
  assign minmax_b = is_abs ? neg_a_i : operand_b_i;

  always_comb begin
    for (int i = 0; i < `ALU_LANES; i++)
      minmax_o[LW*i +: LW] = sel_a[i] ? operand_a_i[LW*i +: LW] : minmax_b[LW*i +: LW];
  end

endmodule

//--- hdl/alu_bitcount.sv
/*
  bit counting ops FF1, FL1, CNT and CLB on the full 32 bit word
  FF1 and FL1 give 32 when no bit is set
  CLB gives 0 for zero and 31 for all ones
*/
`include "alu_settings.svh"

//////////////////////////////////////////////////////////////////////
// find first one, binary tree over LEN bits
//////////////////////////////////////////////////////////////////////

module alu_ff #(
  parameter int LEN = 32
) (
  input  logic [LEN-1:0]                          in_i,
  output logic [((LEN > 1) ? $clog2(LEN) : 1)-1:0] first_one_o,
  output logic                                    no_ones_o
);
  localparam int LVL = (LEN > 1) ? $clog2(LEN) : 1;
  localparam int N   = 2 ** LVL;

  // heap order, node n has children 2n+1 and 2n+2, leaves from N-1
  logic [2*N-2:0] sel_nodes;
  logic [LVL-1:0] idx_nodes [2*N-1];

  for (genvar k = 0; k < N; k++) begin : g_leaf
    if (k < LEN) begin : g_bit
      assign sel_nodes[N-1+k] = in_i[k];
    end else begin : g_pad
      assign sel_nodes[N-1+k] = 1'b0;
    end
    assign idx_nodes[N-1+k] = LVL'(k);
  end

  // the lower half wins when it holds a one
  for (genvar n = 0; n < N - 1; n++) begin : g_node
    assign sel_nodes[n] = sel_nodes[2*n+1] | sel_nodes[2*n+2];
    assign idx_nodes[n] = sel_nodes[2*n+1] ? idx_nodes[2*n+1] : idx_nodes[2*n+2];
  end

  assign first_one_o = idx_nodes[0];
  assign no_ones_o   = ~sel_nodes[0];

endmodule

//////////////////////////////////////////////////////////////////////
// bit count ops
//////////////////////////////////////////////////////////////////////

module alu_bitcount (
  input  alu_op_pkg::alu_op_e operator_i,
  input  logic [`ALU_W-1:0]   operand_a_i,
  output logic [5:0]          bitop_o
);
  import alu_op_pkg::*;

  localparam int IW = $clog2(`ALU_W);
  localparam int LW = `ALU_LANE_W;

  logic [`ALU_W-1:0]      a_scan, a_rev, ff_in;
  logic [IW-1:0]          ff_idx;
  logic                   ff_none;
  logic [$clog2(LW):0]    byte_cnt [`ALU_LANES];
  logic [5:0]             cnt;

  // clb counts leading ones of a negative word as leading zeros of ~a
  assign a_scan = (is_signed_op(operator_i) && operand_a_i[`ALU_W-1]) ? ~operand_a_i
                                                                       : operand_a_i;
  assign a_rev  = {<<{a_scan}};
  assign ff_in  = (operator_i == ALU_FF1) ? operand_a_i : a_rev;

  alu_ff #(.LEN(`ALU_W)) i_ff (
    .in_i        (ff_in),
    .first_one_o (ff_idx),
    .no_ones_o   (ff_none)
  );

  // per-byte counts, then the byte counts are summed
  always_comb begin
    cnt = '0;
    for (int b = 0; b < `ALU_LANES; b++) begin
      byte_cnt[b] = '0;
      for (int i = 0; i < LW; i++)
        byte_cnt[b] = byte_cnt[b] + operand_a_i[LW*b+i];
      cnt = cnt + 6'(byte_cnt[b]);
    end
  end

  always_comb begin
    case (operator_i)
      ALU_FF1: bitop_o = ff_none ? 6'(`ALU_W) : {1'b0, ff_idx};
      ALU_FL1: bitop_o = ff_none ? 6'(`ALU_W) : {1'b0, IW'(`ALU_W - 1) - ff_idx};
      ALU_CNT: bitop_o = cnt;
      ALU_CLB: begin
        if (ff_none)
          bitop_o = operand_a_i[`ALU_W-1] ? 6'(`ALU_W - 1) : 6'd0;
        else
          bitop_o = {1'b0, ff_idx} - 6'd1;
      end
      default: bitop_o = '0;
    endcase
  end

endmodule

//--- hdl/alu_div.sv
/*
  serial restoring divider for DIV, DIVU, REM and REMU
  starts when idle with a division op, result after ALU_DIV_STEPS+1 edges
  operator and operands must stay stable until the result is accepted
  x/0 gives quotient all ones and remainder x
*/
`include "alu_settings.svh"

module alu_div (
  input  logic                clk,
  input  logic                rst_n_i,
  input  alu_op_pkg::alu_op_e operator_i,
  input  logic [`ALU_W-1:0]   operand_a_i,
  input  logic [`ALU_W-1:0]   operand_b_i,
  input  logic                ex_ready_i,
  output logic [`ALU_W-1:0]   div_result_o,
  output logic                ready_o
);
  import alu_op_pkg::*;

  localparam int CW = $clog2(`ALU_DIV_STEPS);

  typedef enum logic [1:0] {DIV_IDLE, DIV_BUSY, DIV_DONE} div_state_e;

  div_state_e        state_q;
  logic [CW-1:0]     step_q;
  logic [`ALU_W-1:0] quot_q, divisor_q, rem_q;
  logic [`ALU_W-1:0] mag_a, mag_b, quot_fix, rem_fix;
  logic [`ALU_W:0]   rem_shift, rem_diff;
  logic              neg_a, neg_b, start, last_step, fits, is_rem;

  // signed operands go in as magnitudes
  assign neg_a = is_signed_op(operator_i) & operand_a_i[`ALU_W-1];
  assign neg_b = is_signed_op(operator_i) & operand_b_i[`ALU_W-1];
  assign mag_a = neg_a ? -operand_a_i : operand_a_i;
  assign mag_b = neg_b ? -operand_b_i : operand_b_i;

  assign start     = (state_q == DIV_IDLE) && is_div_op(operator_i);
  assign last_step = (step_q == CW'(`ALU_DIV_STEPS - 1));

  // next dividend bit shifts into the partial remainder
  assign rem_shift = {rem_q, quot_q[`ALU_W-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_q};
  assign fits      = (rem_shift >= {1'b0, divisor_q});

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= DIV_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: if (start) begin
          state_q <= DIV_BUSY;
          step_q  <= '0;
        end
        DIV_BUSY: begin
          step_q <= step_q + 1'b1;
          if (last_step)
            state_q <= DIV_DONE;
        end
        // result held until the stage takes it
        DIV_DONE: if (ex_ready_i)
          state_q <= DIV_IDLE;
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // quotient bits replace the dividend from the bottom
  always_ff @(posedge clk) begin
    if (start) begin
      quot_q    <= mag_a;
      divisor_q <= mag_b;
      rem_q     <= '0;
    end else if (state_q == DIV_BUSY) begin
      rem_q  <= fits ? rem_diff[`ALU_W-1:0] : rem_shift[`ALU_W-1:0];
      quot_q <= {quot_q[`ALU_W-2:0], fits};
    end
  end

  assign ready_o = (state_q == DIV_DONE) ||
                   ((state_q == DIV_IDLE) && !is_div_op(operator_i));

  // quotient negative on differing signs, remainder follows a
  assign quot_fix = (neg_a ^ neg_b) ? -quot_q : quot_q;
  assign rem_fix  = neg_a ? -rem_q : rem_q;
  assign is_rem   = operator_i inside {ALU_REM, ALU_REMU};

  always_comb begin
    if (operand_b_i == '0)
      div_result_o = is_rem ? operand_a_i : '1;
    else
      div_result_o = is_rem ? rem_fix : quot_fix;
  end

endmodule

//--- hdl/riscv_alu.sv
/*
  execute stage integer ALU with 32/16/8 bit lane modes
  everything but division is combinational and ready_o stays high
  for DIV/DIVU/REM/REMU the operator and operands must stay stable
  until ready_o and ex_ready_i are both high at a clock edge
*/
`include "alu_settings.svh"

module riscv_alu (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  alu_op_pkg::alu_op_e     operator_i,
  input  alu_lane_pkg::vec_mode_e vector_mode_i,
  input  logic [`ALU_W-1:0]       operand_a_i,
  input  logic [`ALU_W-1:0]       operand_b_i,
  input  logic                    ex_ready_i,
  output logic [`ALU_W-1:0]       result_o,
  output logic                    comparison_result_o,
  output logic                    ready_o
);
  import alu_op_pkg::*;

  logic [`ALU_W-1:0] sum, neg_a, shift_res, minmax, div_res;
  logic [5:0]        bitop;

  //////////////////////////////////////////////////////////////////////
  // datapath blocks
  //////////////////////////////////////////////////////////////////////

  alu_vec_adder i_adder (
    .operator_i    (operator_i),
    .vector_mode_i (vector_mode_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .sum_o         (sum),
    .neg_a_o       (neg_a)
  );

  alu_vec_shifter i_shifter (
    .operator_i     (operator_i),
    .vector_mode_i  (vector_mode_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .shift_result_o (shift_res)
  );

  // abs reuses the lane negation of the adder
  alu_vec_compare i_compare (
    .operator_i          (operator_i),
    .vector_mode_i       (vector_mode_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .neg_a_i             (neg_a),
    .comparison_result_o (comparison_result_o),
    .minmax_o            (minmax)
  );

  alu_bitcount i_bitcount (
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .bitop_o     (bitop)
  );

  alu_div i_div (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .operator_i   (operator_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .ex_ready_i   (ex_ready_i),
    .div_result_o (div_res),
    .ready_o      (ready_o)
  );

  //////////////////////////////////////////////////////////////////////
  // result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    if (is_div_op(operator_i)) begin
      result_o = div_res;
    end else if (is_cmp_op(operator_i)) begin
      // compare bit of the top lane, zero extended
      result_o = {{(`ALU_W-1){1'b0}}, comparison_result_o};
    end else begin
      case (operator_i)
        ALU_AND:                               result_o = operand_a_i & operand_b_i;
        ALU_OR:                                result_o = operand_a_i | operand_b_i;
        ALU_XOR:                               result_o = operand_a_i ^ operand_b_i;
        ALU_ADD, ALU_SUB:                      result_o = sum;
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROR:    result_o = shift_res;
        ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
        ALU_ABS:                               result_o = minmax;
        ALU_FF1, ALU_FL1, ALU_CNT, ALU_CLB:    result_o = {{(`ALU_W-6){1'b0}}, bitop};
        default: ;
      endcase
    end
  end

endmodule

//--- verif/alu_checker.sv
/*
  concurrent checks on the ALU handshake, bound into riscv_alu
  assumes the stage holds operator and operands of a division
  until the result is accepted
*/
`include "alu_settings.svh"

module alu_checker (
  input logic                clk,
  input logic                rst_n_i,
  input alu_op_pkg::alu_op_e operator_i,
  input logic                ex_ready_i,
  input logic [`ALU_W-1:0]   result_i,
  input logic                ready_i
);
  import alu_op_pkg::*;

  logic [7:0] low_cnt;
  logic       div_op;

  assign div_op = is_div_op(operator_i);

  // consecutive edges with ready low, saturates
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      low_cnt <= '0;
    end else if (ready_i) begin
      low_cnt <= '0;
    end else if (low_cnt != '1) begin
      low_cnt <= low_cnt + 1'b1;
    end
  end

  // non-division ops never stall the stage
  a_ready_comb: assert property (@(posedge clk) disable iff (!rst_n_i)
    !div_op |-> ready_i)
    else $error("ready_o low for a non-division operator");

  // a finished division waits for the stage
  a_result_held: assert property (@(posedge clk) disable iff (!rst_n_i)
    div_op && ready_i && !ex_ready_i |=> ready_i && $stable(result_i))
    else $error("division result changed before it was accepted");

  // no result before start edge plus all steps
  a_div_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    div_op && ready_i && (low_cnt != '0) |-> low_cnt >= 8'(`ALU_DIV_STEPS + 1))
    else $error("ready_o rose while a division was still busy");

endmodule

bind riscv_alu alu_checker i_checker (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .operator_i (operator_i),
  .ex_ready_i (ex_ready_i),
  .result_i   (result_o),
  .ready_i    (ready_o)
);

//--- verif/tb_alu.sv
/*
  testbench for the vector ALU, run from the project root
  vectors come from verif/alu_testdata.txt
  combinational ops are checked at the falling edge after they are driven
  divisions wait for ready_o, hold the result for a few cycles, then accept
*/
`include "alu_settings.svh"

//////////////////////////////////////////////////////////////////////
// clock and reset
//////////////////////////////////////////////////////////////////////

module tb_clk_gen #(
  parameter int PERIOD      = 20,
  parameter int RESET_TICKS = 2
) (
  output logic clk_o,
  output logic rst_n_o
);
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // released on a rising edge, the DUT reset is synchronous
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_TICKS) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end
endmodule

//////////////////////////////////////////////////////////////////////
// testbench top
//////////////////////////////////////////////////////////////////////

module tb_alu;
  import alu_op_pkg::*;
  import alu_lane_pkg::*;

  localparam int    CLK_PERIOD    = 20;
  localparam string DATA_FILE     = "verif/alu_testdata.txt";
  localparam int    RESET_TIMEOUT = 10;
  localparam int    DIV_TIMEOUT   = 4 * `ALU_DIV_STEPS;
  localparam int    HOLD_CYCLES   = 4;
  // cmp column value of vectors whose compare bit is ignored
  localparam logic [3:0] CMP_SKIP = 4'h2;

  logic              clk, rst_n;
  alu_op_e           operator;
  vec_mode_e         vector_mode;
  logic [`ALU_W-1:0] operand_a, operand_b, result;
  logic              ex_ready, comparison_result, ready;
  int                vec_no;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_TICKS(2)) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  riscv_alu i_dut (
    .clk                 (clk),
    .rst_n_i             (rst_n),
    .operator_i          (operator),
    .vector_mode_i       (vector_mode),
    .operand_a_i         (operand_a),
    .operand_b_i         (operand_b),
    .ex_ready_i          (ex_ready),
    .result_o            (result),
    .comparison_result_o (comparison_result),
    .ready_o             (ready)
  );

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "stopped at vector %0d", vec_no);
  endtask

  task automatic check_value(input string name, input logic [`ALU_W-1:0] expected,
                             input logic [`ALU_W-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s: expected 0x%h, got 0x%h (vector %0d)",
               name, expected, actual, vec_no);
      abort_run();
    end
  endtask

  // new inputs on the rising edge, outputs looked at on the falling one
  task automatic apply_vector(input logic [5:0] op, input logic [1:0] mode,
                              input logic [`ALU_W-1:0] a, input logic [`ALU_W-1:0] b);
    @(posedge clk);
    operator    <= alu_op_e'(op);
    vector_mode <= vec_mode_e'(mode);
    operand_a   <= a;
    operand_b   <= b;
    ex_ready    <= 1'b0;
    @(negedge clk);
  endtask

  task automatic run_division(input logic [`ALU_W-1:0] exp_res);
    int waited;
    waited = 0;
    while (!ready && waited < DIV_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!ready) begin
      $display("division at vector %0d gave no result within %0d cycles",
               vec_no, DIV_TIMEOUT);
      abort_run();
    end
    check_value("result_o", exp_res, result);
    // stage stalled, result must stay put
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      @(negedge clk);
      check_value("ready_o", 1, ready);
      check_value("result_o", exp_res, result);
    end
    @(posedge clk);
    ex_ready <= 1'b1;
    // taken at the next rising edge
    @(negedge clk);
    check_value("ready_o", 1, ready);
  endtask

  initial begin
    int                fd;
    int                n_fields;
    int                waited;
    string             line;
    logic [5:0]        op_v;
    logic [1:0]        mode_v;
    logic [`ALU_W-1:0] a_v, b_v, exp_v;
    logic [3:0]        cmp_v;

    operator    = ALU_ADD;
    vector_mode = VEC_MODE32;
    operand_a   = '0;
    operand_b   = '0;
    ex_ready    = 1'b0;
    vec_no      = 0;

    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was not released within %0d cycles", RESET_TIMEOUT);
      abort_run();
    end

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", DATA_FILE);
      abort_run();
    end

    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip blank and comment lines
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n_fields = $sscanf(line, "%h %h %h %h %h %h", op_v, mode_v, a_v, b_v, exp_v, cmp_v);
      if (n_fields != 6) begin
        $display("malformed line in %s: %s", DATA_FILE, line);
        abort_run();
      end
      vec_no++;
      apply_vector(op_v, mode_v, a_v, b_v);
      if (alu_op_e'(op_v) inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU}) begin
        run_division(exp_v);
      end else begin
        check_value("ready_o", 1, ready);
        check_value("result_o", exp_v, result);
        if (cmp_v != CMP_SKIP)
          check_value("comparison_result_o", {31'b0, cmp_v[0]}, {31'b0, comparison_result});
      end
    end
    $fclose(fd);

    if (vec_no == 0) begin
      $display("no test vectors found in %s", DATA_FILE);
      abort_run();
    end else begin
      $display("checked %0d vectors", vec_no);
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- verif/alu_testdata.txt
# op mode operand_a operand_b result cmp, all hex
# mode 0/2/3 = 32/16/8 bit lanes, cmp 2 = compare bit not checked
15 0 f0f0ff00 0ff0f0f0 00f0f000 2
2e 0 f0f0ff00 0ff0f0f0 fff0fff0 2
2f 0 f0f0ff00 0ff0f0f0 ff000ff0 2
18 0 00ff00ff 00010001 01000100 2
18 3 00ff00ff 00010001 00000000 2
18 2 7fff8000 00018000 80000000 2
19 0 00000000 00000001 ffffffff 2
19 3 10000105 01020304 0ffefe01 2
19 2 00010000 00020001 ffffffff 2
27 0 00000001 0000001f 80000000 2
25 0 80000000 00000004 08000000 2
24 0 80000000 00000004 f8000000 2
27 3 01010101 00010203 01020408 2
25 3 80808080 07050301 01041040 2
24 3 80808080 07050301 fffcf0c0 2
24 2 80000100 00040008 f8000001 2
27 2 00018001 00010004 00020010 2
26 0 00000001 00000001 80000000 2
26 0 12345678 00000008 78123456 2
0c 0 12345678 12345678 00000001 1
0d 0 12345678 12345679 00000001 1
00 0 80000000 00000001 00000001 1
01 0 80000000 00000001 00000000 0
08 3 7f000080 80000001 00000001 1
09 3 7f000000 80000000 00000000 0
0a 2 ffff0000 ffff1234 00000001 1
05 2 00020000 0001ffff 00000000 0
0b 0 00000000 00000001 00000000 0
04 3 fe112233 ff000000 00000001 1
10 3 7f80ff01 80017f02 8080ff01 2
13 2 00018000 ffff7fff ffff8000 2
14 3 80ff017f 00000000 8001017f 2
14 2 fffe0005 00000000 00020005 2
14 0 80000000 00000000 80000000 2
36 0 00000000 00000000 00000020 2
36 0 00000100 00000000 00000008 2
36 0 ffffffff 00000000 00000000 2
37 0 00000000 00000000 00000020 2
37 0 00000100 00000000 00000008 2
37 0 ffffffff 00000000 0000001f 2
34 0 ffffffff 00000000 00000020 2
34 0 00000000 00000000 00000000 2
34 0 f0f00001 00000000 00000009 2
35 0 00000000 00000000 00000000 2
35 0 ffffffff 00000000 0000001f 2
35 0 00010000 00000000 0000000e 2
35 0 fffe0000 00000000 0000000e 2
35 0 00000001 00000000 0000001e 2
30 0 00000064 00000007 0000000e 2
32 0 00000064 00000007 00000002 2
31 0 ffffff9c 00000007 fffffff2 2
33 0 ffffff9c 00000007 fffffffe 2
31 0 00000064 fffffff9 fffffff2 2
33 0 00000064 fffffff9 00000002 2
31 0 80000000 ffffffff 80000000 2
33 0 80000000 ffffffff 00000000 2
30 0 ffffffff 00000010 0fffffff 2
32 0 ffffffff 00000010 0000000f 2
30 0 12345678 00000000 ffffffff 2
32 0 12345678 00000000 12345678 2
31 0 fffffff0 00000000 ffffffff 2
18 0 00000001 00000002 00000003 2

//--- build.f
+incdir+include
hdl/alu_op_pkg.sv
hdl/alu_lane_pkg.sv
hdl/alu_vec_adder.sv
hdl/alu_vec_shifter.sv
hdl/alu_vec_compare.sv
hdl/alu_bitcount.sv
hdl/alu_div.sv
hdl/riscv_alu.sv
verif/alu_checker.sv
verif/tb_alu.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_alu \
  -Mdir obj_dir -o sim_alu
./obj_dir/sim_alu > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF "** FAIL **" "$LOG"; then
  exit 1
fi
if ! grep -qF "** PASS **" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
